// ==== verilog.f ====
hdl/wbuf_pkg.sv
hdl/wbuf_store.sv
hdl/wbuf_tx_issue.sv
hdl/wbuf_tx_tracker.sv
hdl/wbuf_top.sv
sim/wbuf_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the write buffer testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module wbuf_tb -f verilog.f -o wbuf_sim

status=0
./obj_dir/wbuf_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "simulation reported a failure (exit status $status)"
  exit 1
fi
grep -q "TESTS PASSED" sim.log

// ==== sim/wbuf_tests.txt ====
# name cmd args, numbers in hex: W addr be data | H mode (0 random ack, 1 hold, 2 always ack)
# E G addr grant | E T transfer count since the last E T | D drain and compare memory
coal_hold      H 1
coal_w0        W 00001000 f 11111111
coal_w1        W 00001004 f 22222222
coal_w2        W 00001010 f 33333333
coal_w3        W 00002000 f 44444444
coal_miss      E G 00003000 0
coal_merge     W 00001006 c aabb0000
coal_hit       E G 00001010 1
coal_release   H 0
coal_drain     D
coal_count     E T 4
split_hold     H 1
split_w9       W 00004000 9 d4c3b2a1
split_wf       W 00004004 f 87654321
split_w6       W 00004008 6 00fe0d00
split_w7       W 0000400c 7 00332211
split_release  H 0
split_drain    D
split_count    E T 7
rew_hold       H 1
rew_w0         W 00005000 f 01020304
rew_ack        H 2
rew_w1         W 00005000 f a0b0c0d0
rew_w2         W 00005000 2 00005500
rew_release    H 0
rew_drain      D
rew_count      E T 2
mix_w0         W 00007000 f 10203040
mix_w1         W 00007004 3 00005566
mix_w2         W 00007008 c 77880000
mix_w3         W 00007000 2 0000ab00
mix_w4         W 0000700c 1 000000cd
mix_w5         W 00007010 f cafe0001
mix_w6         W 00007004 c 99aa0000
mix_w7         W 00007014 8 ee000000
mix_w8         W 00007008 3 0000f00d
mix_w9         W 00007000 f 0badf00d
mix_drain      D

// ==== sim/wbuf_tb.sv ====
// testbench for wbuf_top with depth 4 and 4 slots; run from the project root to find the tests
`timescale 1ns/10ps
`default_nettype none

module wbuf_tb;

  localparam int depth        = 4;
  localparam int max_tx       = 4;
  localparam int max_cmds     = 128;
  // longer than a full eviction burst plus one reissue
  localparam int quiet_cycles = 12;

  logic                          clk_i, rst_ni;
  logic                          wr_valid_i, wr_gnt_o;
  wbuf_pkg::wr_req_t             wr_req_i;
  logic                          mem_valid_o, mem_ack_i;
  wbuf_pkg::mem_req_t            mem_req_o;
  logic                          rtrn_valid_i;
  logic [wbuf_pkg::id_width-1:0] rtrn_id_i;
  logic                          empty_o;

  wbuf_top #(
    .depth  (depth),
    .max_tx (max_tx)
  ) dut (
    .clk_i, .rst_ni,
    .wr_valid_i, .wr_req_i, .wr_gnt_o,
    .mem_valid_o, .mem_req_o, .mem_ack_i,
    .rtrn_valid_i, .rtrn_id_i,
    .empty_o
  );

  // command table filled from the test file
  logic [8*24-1:0] t_name [max_cmds];
  logic [7:0]      t_cmd  [max_cmds];
  logic [7:0]      t_kind [max_cmds];
  logic [31:0]     t_a    [max_cmds];
  logic [31:0]     t_b    [max_cmds];
  logic [31:0]     t_c    [max_cmds];
  int              n_cmds;

  integer          seed;
  int              cycles, limit, ack_mode, xfer_cnt;
  logic [8*24-1:0] cur_name;
  // outputs as seen just before the last rising edge
  logic            wr_taken, gnt_seen, valid_seen;

  // byte images of the latest core data and of what memory received
  logic [7:0] ref_img [logic [31:0]];
  logic [7:0] mem_img [logic [31:0]];
  // bytes written and not yet handed to memory, per word
  logic [wbuf_pkg::data_bytes-1:0] unsent [logic [wbuf_pkg::wtag_width-1:0]];

  // memory view of outstanding transfers
  logic [max_tx-1:0]               inflight_vld;
  logic [wbuf_pkg::wtag_width-1:0] inflight_tag [max_tx];
  logic [wbuf_pkg::id_width-1:0]   pend_id [$];
  int                              pend_dly [$];

  ////////////////////////////////////////
  // reporting
  ////////////////////////////////////////

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "write buffer testbench stopped");
  endtask

  task automatic abort_run(input string why);
    $display("ERROR in %0s: %0s", cur_name, why);
    stop_run();
  endtask

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %0s, %0s: expected 0x%0h, actual 0x%0h", cur_name, what, exp, act);
      stop_run();
    end
  endtask

  ////////////////////////////////////////
  // transfer split rules
  ////////////////////////////////////////

  // first unsent byte of a word, data_bytes when none is left
  function automatic int lowest_set(input logic [wbuf_pkg::data_bytes-1:0] mask);
    int first;
    first = 0;
    while (first < wbuf_pkg::data_bytes && !mask[first]) begin
      first++;
    end
    return first;
  endfunction

  // widest naturally aligned run of unsent bytes that begins at start
  function automatic int widest_run(input logic [wbuf_pkg::data_bytes-1:0] mask,
                                    input int start);
    int   width;
    logic full;
    width = 1;
    for (int n = 2; n <= wbuf_pkg::data_bytes; n = n * 2) begin
      full = ((start % n) == 0);
      for (int b = start; b < start + n; b++) begin
        if (b >= wbuf_pkg::data_bytes || !mask[b]) begin
          full = 1'b0;
        end
      end
      if (full) begin
        width = n;
      end
    end
    return width;
  endfunction

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  task automatic drive_ack();
    case (ack_mode)
      1:       mem_ack_i = 1'b0;
      2:       mem_ack_i = 1'b1;
      default: mem_ack_i = (($random(seed) % 2) != 0);
    endcase
  endtask

  // ack then at most one response picked at random among the due ones
  task automatic drive_mem();
    int ready_n;
    int pick;
    drive_ack();
    rtrn_valid_i = 1'b0;
    ready_n = 0;
    foreach (pend_dly[i]) begin
      if (pend_dly[i] == 0) begin
        ready_n++;
      end else begin
        pend_dly[i]--;
      end
    end
    if (ready_n > 0) begin
      pick = int'($unsigned($random(seed)) % ready_n);
      for (int i = 0; i < pend_dly.size(); i++) begin
        if (pend_dly[i] == 0) begin
          if (pick == 0) begin
            rtrn_valid_i = 1'b1;
            rtrn_id_i    = pend_id[i];
            inflight_vld[pend_id[i]] = 1'b0;
            pend_id.delete(i);
            pend_dly.delete(i);
            break;
          end
          pick--;
        end
      end
    end
  endtask

  // handshakes taken at this edge; transfer first, so it is checked against older data
  task automatic observe();
    logic [31:0]                     base;
    logic [wbuf_pkg::wtag_width-1:0] tag;
    logic [wbuf_pkg::data_bytes-1:0] mask;
    int                              off, nb, busy;
    gnt_seen   = wr_gnt_o;
    valid_seen = mem_valid_o;
    if (mem_valid_o && mem_ack_i) begin
      xfer_cnt++;
      base = {mem_req_o.addr[31:2], 2'b00};
      off  = int'(mem_req_o.addr[1:0]);
      nb   = 1 << mem_req_o.size;
      if (mem_req_o.size > wbuf_pkg::size_word || (off % nb) != 0) begin
        abort_run("memory transfer is not naturally aligned");
      end
      tag  = mem_req_o.addr[31:2];
      mask = unsent.exists(tag) ? unsent[tag] : '0;
      check("transfer offset", lowest_set(mask), off);
      check("transfer size in bytes", widest_run(mask, off), nb);
      busy = 0;
      for (int s = 0; s < max_tx; s++) begin
        if (inflight_vld[s] && inflight_tag[s] == mem_req_o.addr[31:2]) begin
          busy++;
        end
      end
      check("word already in flight", 0, busy);
      check("id already in flight", 0, inflight_vld[mem_req_o.id]);
      for (int b = off; b < off + nb; b++) begin
        if (!ref_img.exists(base + b)) begin
          abort_run("transfer holds a byte that was never written");
        end
        check($sformatf("data byte %h", base + b), ref_img[base + b],
              mem_req_o.data[b*8 +: 8]);
        mem_img[base + b] = mem_req_o.data[b*8 +: 8];
        mask[b] = 1'b0;
      end
      unsent[tag] = mask;
      inflight_vld[mem_req_o.id] = 1'b1;
      inflight_tag[mem_req_o.id] = mem_req_o.addr[31:2];
      pend_id.push_back(mem_req_o.id);
      pend_dly.push_back(1 + int'($unsigned($random(seed)) % 6));
    end
    if (wr_valid_i && wr_gnt_o) begin
      wr_taken = 1'b1;
      tag  = wr_req_i.addr[31:2];
      mask = unsent.exists(tag) ? unsent[tag] : '0;
      unsent[tag] = mask | wr_req_i.be;
      for (int j = 0; j < wbuf_pkg::data_bytes; j++) begin
        if (wr_req_i.be[j]) begin
          ref_img[{wr_req_i.addr[31:2], 2'b00} + j] = wr_req_i.data[j*8 +: 8];
        end
      end
    end
  endtask

  // one clock with sampling at the rising edge and driving at the falling edge
  task automatic step();
    @(posedge clk_i);
    observe();
    @(negedge clk_i);
    drive_mem();
    cycles++;
    if (cycles > limit) begin
      abort_run("run did not finish within the cycle limit");
    end
  endtask

  ////////////////////////////////////////
  // commands
  ////////////////////////////////////////

  task automatic write_word(input logic [31:0] addr, input logic [31:0] be,
                            input logic [31:0] data);
    wr_req_i.addr = addr;
    wr_req_i.be   = be[wbuf_pkg::data_bytes-1:0];
    wr_req_i.data = data;
    wr_valid_i    = 1'b1;
    wr_taken      = 1'b0;
    // core holds the request until granted
    while (!wr_taken) begin
      step();
    end
    wr_valid_i = 1'b0;
    // the written word now occupies an entry
    check("empty flag after write", 0, empty_o);
  endtask

  // grant looked at with valid low, so nothing is written
  task automatic probe_grant(input logic [31:0] addr, input logic [31:0] exp);
    wr_valid_i    = 1'b0;
    wr_req_i.addr = addr;
    step();
    check("grant", exp, gnt_seen);
  endtask

  task automatic drain();
    int quiet;
    quiet      = 0;
    wr_valid_i = 1'b0;
    while (quiet < quiet_cycles) begin
      step();
      if (pend_id.size() == 0 && !rtrn_valid_i && !valid_seen) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    check("empty flag", 1, empty_o);
    check("image size", ref_img.num(), mem_img.num());
    foreach (ref_img[a]) begin
      if (!mem_img.exists(a)) begin
        abort_run("a written byte never reached memory");
      end
      check($sformatf("memory byte %h", a), ref_img[a], mem_img[a]);
    end
  endtask

  task automatic load_tests();
    integer           fd, r;
    logic [8*24-1:0]  tok, kind;
    logic [8*128-1:0] rest;
    fd = $fopen("sim/wbuf_tests.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open sim/wbuf_tests.txt");
    end
    n_cmds = 0;
    while (!$feof(fd)) begin
      r = $fscanf(fd, "%s", tok);
      if (r != 1) begin
        break;
      end
      if (tok == "#") begin
        r = $fgets(rest, fd);
      end else begin
        cur_name       = tok;
        t_name[n_cmds] = tok;
        t_a[n_cmds]    = '0;
        t_b[n_cmds]    = '0;
        t_c[n_cmds]    = '0;
        t_kind[n_cmds] = '0;
        r = $fscanf(fd, "%s", tok);
        t_cmd[n_cmds] = tok[7:0];
        case (tok[7:0])
          "W": begin
            r = $fscanf(fd, "%h %h %h", t_a[n_cmds], t_b[n_cmds], t_c[n_cmds]);
            if (r != 3) begin
              abort_run("write command needs address, byte enables and data");
            end
          end
          "H": r = $fscanf(fd, "%d", t_a[n_cmds]);
          "E": begin
            r = $fscanf(fd, "%s", kind);
            t_kind[n_cmds] = kind[7:0];
            if (kind[7:0] == "G") begin
              r = $fscanf(fd, "%h %h", t_a[n_cmds], t_b[n_cmds]);
            end else begin
              r = $fscanf(fd, "%h", t_a[n_cmds]);
            end
          end
          "D": r = 0;
          default: abort_run("unknown command in the test file");
        endcase
        n_cmds++;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_command(input int i);
    cur_name = t_name[i];
    case (t_cmd[i])
      "W": write_word(t_a[i], t_b[i], t_c[i]);
      "H": begin
        ack_mode = int'(t_a[i]);
        drive_ack();
      end
      "E": begin
        if (t_kind[i] == "G") begin
          probe_grant(t_a[i], t_b[i]);
        end else begin
          check("transfer count", t_a[i], xfer_cnt);
          xfer_cnt = 0;
        end
      end
      "D": drain();
      default: abort_run("unknown command");
    endcase
  endtask

  ////////////////////////////////////////
  // clock, reset and command loop
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    rst_ni       = 1'b0;
    wr_valid_i   = 1'b0;
    wr_req_i     = '0;
    mem_ack_i    = 1'b0;
    rtrn_valid_i = 1'b0;
    rtrn_id_i    = '0;
    seed         = 32'hc0c2;
    cycles       = 0;
    ack_mode     = 0;
    xfer_cnt     = 0;
    wr_taken     = 1'b0;
    gnt_seen     = 1'b0;
    valid_seen   = 1'b0;
    inflight_vld = '0;
    cur_name     = "load";
    load_tests();
    limit = 200 * n_cmds;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < n_cmds; i++) begin
      run_command(i);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/wbuf_top.sv ====
// write buffer top; depth 2..16, max_tx 2..8, responses one per cycle in any order
`timescale 1ns/10ps
`default_nettype none

module wbuf_top #(
  parameter int depth  = 4,
  parameter int max_tx = 4
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  // core side
  input  wire logic                           wr_valid_i,
  input  wire wbuf_pkg::wr_req_t              wr_req_i,
  output logic                                wr_gnt_o,
  // memory side
  output logic                                mem_valid_o,
  output wbuf_pkg::mem_req_t                  mem_req_o,
  input  wire logic                           mem_ack_i,
  input  wire logic                           rtrn_valid_i,
  input  wire logic [wbuf_pkg::id_width-1:0]  rtrn_id_i,
  output logic                                empty_o
);

  wbuf_pkg::wbuf_entry_t [depth-1:0] entries;
  logic [max_tx-1:0]                 slot_free;
  // accepted transfer
  logic                              issue;
  logic [wbuf_pkg::ptr_width-1:0]    issue_ptr;
  logic [wbuf_pkg::data_bytes-1:0]   issue_be;
  logic [wbuf_pkg::id_width-1:0]     issue_id;
  // returned transfer
  logic                              evict;
  logic [wbuf_pkg::ptr_width-1:0]    evict_ptr;
  logic [wbuf_pkg::data_bytes-1:0]   evict_be;

  wbuf_store #(
    .depth (depth)
  ) u_store (
    .clk_i, .rst_ni,
    .wr_valid_i,
    .wr_req_i,
    .wr_gnt_o,
    .issue_i     (issue),
    .issue_ptr_i (issue_ptr),
    .issue_be_i  (issue_be),
    .evict_i     (evict),
    .evict_ptr_i (evict_ptr),
    .evict_be_i  (evict_be),
    .entries_o   (entries),
    .empty_o
  );

  wbuf_tx_issue #(
    .depth  (depth),
    .max_tx (max_tx)
  ) u_tx_issue (
    .clk_i, .rst_ni,
    .entries_i   (entries),
    .slot_free_i (slot_free),
    .mem_ack_i,
    .mem_req_o,
    .mem_valid_o,
    .issue_o     (issue),
    .issue_ptr_o (issue_ptr),
    .issue_be_o  (issue_be),
    .issue_id_o  (issue_id)
  );

  wbuf_tx_tracker #(
    .max_tx (max_tx)
  ) u_tx_tracker (
    .clk_i, .rst_ni,
    .issue_i     (issue),
    .issue_ptr_i (issue_ptr),
    .issue_be_i  (issue_be),
    .issue_id_i  (issue_id),
    .rtrn_valid_i,
    .rtrn_id_i,
    .slot_free_o (slot_free),
    .evict_o     (evict),
    .evict_ptr_o (evict_ptr),
    .evict_be_o  (evict_be)
  );

endmodule

`default_nettype wire

// ==== hdl/wbuf_tx_tracker.sv ====
// slot tracking; at most one response per cycle, every response ID must be outstanding
`timescale 1ns/10ps
`default_nettype none

module wbuf_tx_tracker #(
  parameter int max_tx = 4
) (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  // accepted transfer
  input  wire logic                                issue_i,
  input  wire logic [wbuf_pkg::ptr_width-1:0]      issue_ptr_i,
  input  wire logic [wbuf_pkg::data_bytes-1:0]     issue_be_i,
  input  wire logic [wbuf_pkg::id_width-1:0]       issue_id_i,
  // write responses
  input  wire logic                                rtrn_valid_i,
  input  wire logic [wbuf_pkg::id_width-1:0]       rtrn_id_i,
  output logic [max_tx-1:0]                        slot_free_o,
  // eviction towards the store
  output logic                                     evict_o,
  output logic [wbuf_pkg::ptr_width-1:0]           evict_ptr_o,
  output logic [wbuf_pkg::data_bytes-1:0]          evict_be_o
);

  localparam int ptr_w = (max_tx > 1) ? $clog2(max_tx) : 1;
  localparam int cnt_w = $clog2(max_tx + 1);

  wbuf_pkg::tx_slot_t [max_tx-1:0] slots_q, slots_d;

  // return-ID FIFO with a registered output
  logic [max_tx-1:0][wbuf_pkg::id_width-1:0] fifo_q;
  logic [ptr_w-1:0]                          wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0]                          count_q;
  logic [wbuf_pkg::id_width-1:0]             pop_id;

  ////////////////////////////////////////
  // return FIFO
  ////////////////////////////////////////

  assign evict_o = (count_q != '0);
  assign pop_id  = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rtrn_valid_i) begin
      fifo_q[wr_ptr_q] <= rtrn_id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (rtrn_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(max_tx - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      // one pop per cycle whenever something is queued
      if (evict_o) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(max_tx - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({rtrn_valid_i, evict_o})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  ////////////////////////////////////////
  // slot status
  ////////////////////////////////////////

  assign evict_ptr_o = slots_q[pop_id].ptr;
  assign evict_be_o  = slots_q[pop_id].be;

  for (genvar s = 0; s < max_tx; s++) begin : gen_free
    assign slot_free_o[s] = ~slots_q[s].vld;
  end

  // issue takes a free slot and eviction frees a busy one so they never meet
  always_comb begin
    slots_d = slots_q;
    if (evict_o) begin
      slots_d[pop_id].vld = 1'b0;
    end
    if (issue_i) begin
      slots_d[issue_id_i] = '{vld: 1'b1, ptr: issue_ptr_i, be: issue_be_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slots_q <= '0;
    end else begin
      slots_q <= slots_d;
    end
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  a_pop_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) evict_o |-> slots_q[pop_id].vld)
    else $error("tracker: response names a slot with no transfer outstanding");

  // queued IDs never outnumber the slots, so a full FIFO means a stray response
  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_ni) rtrn_valid_i |-> (count_q != cnt_w'(max_tx)))
    else $error("tracker: return FIFO overflow");

endmodule

`default_nettype wire

// ==== hdl/wbuf_tx_issue.sv ====
// transfer selection; only words with no byte in flight are offered, transfers are aligned
`timescale 1ns/10ps
`default_nettype none

module wbuf_tx_issue #(
  parameter int depth  = 4,
  parameter int max_tx = 4
) (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  input  wire wbuf_pkg::wbuf_entry_t [depth-1:0]   entries_i,
  input  wire logic [max_tx-1:0]                   slot_free_i,
  // memory handshake
  input  wire logic                                mem_ack_i,
  output wbuf_pkg::mem_req_t                       mem_req_o,
  output logic                                     mem_valid_o,
  // accepted transfer, to store and tracker
  output logic                                     issue_o,
  output logic [wbuf_pkg::ptr_width-1:0]           issue_ptr_o,
  output logic [wbuf_pkg::data_bytes-1:0]          issue_be_o,
  output logic [wbuf_pkg::id_width-1:0]            issue_id_o
);

  logic [depth-1:0][wbuf_pkg::data_bytes-1:0] bdirty;
  logic [depth-1:0]                           cand;
  logic [wbuf_pkg::ptr_width-1:0]             rr_q, sel;
  logic                                       any_cand, any_slot;
  wbuf_pkg::wbuf_entry_t                      ent;
  logic [wbuf_pkg::data_bytes-1:0]            bd;
  logic [wbuf_pkg::offset_width-1:0]          off;
  logic [1:0]                                 size;
  logic [wbuf_pkg::data_width-1:0]            req_data;

  ////////////////////////////////////////
  // entry choice
  ////////////////////////////////////////

  // a word with a transfer out is held back since memory may reorder writes
  for (genvar k = 0; k < depth; k++) begin : gen_cand
    assign bdirty[k] = (|entries_i[k].txblock) ? '0 : (entries_i[k].dirty & entries_i[k].valid);
    assign cand[k]   = |bdirty[k];
  end

  // first candidate at or after the round-robin pointer
  always_comb begin
    int idx;
    sel      = '0;
    any_cand = 1'b0;
    for (int i = depth - 1; i >= 0; i--) begin
      idx = (int'(rr_q) + i) % depth;
      if (cand[idx]) begin
        sel      = wbuf_pkg::ptr_width'(idx);
        any_cand = 1'b1;
      end
    end
  end

  // move past the served entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (issue_o) begin
      rr_q <= (sel == wbuf_pkg::ptr_width'(depth - 1)) ? '0 : sel + 1'b1;
    end
  end

  ////////////////////////////////////////
  // size and byte-enable split
  ////////////////////////////////////////

  assign ent = entries_i[sel];
  assign bd  = bdirty[sel];

  always_comb begin
    // lowest dirty offset
    off = '0;
    for (int j = wbuf_pkg::data_bytes - 1; j >= 0; j--) begin
      if (bd[j]) begin
        off = wbuf_pkg::offset_width'(j);
      end
    end
    // largest aligned size that is fully dirty
    if (bd == 4'b1111) begin
      size = wbuf_pkg::size_word;
    end else if (!off[0] && bd[{off[1], 1'b1}]) begin
      size = wbuf_pkg::size_half;
    end else begin
      size = wbuf_pkg::size_byte;
    end
    case (size)
      wbuf_pkg::size_word: begin
        issue_be_o = 4'b1111;
        req_data   = ent.data;
      end
      wbuf_pkg::size_half: begin
        issue_be_o = 4'b0011 << off;
        req_data   = {2{ent.data[{off[1], 4'b0000} +: 16]}};
      end
      default: begin
        issue_be_o = 4'b0001 << off;
        req_data   = {4{ent.data[{off, 3'b000} +: 8]}};
      end
    endcase
  end

  ////////////////////////////////////////
  // slot choice and handshake
  ////////////////////////////////////////

  always_comb begin
    issue_id_o = '0;
    any_slot   = 1'b0;
    for (int s = max_tx - 1; s >= 0; s--) begin
      if (slot_free_i[s]) begin
        issue_id_o = wbuf_pkg::id_width'(s);
        any_slot   = 1'b1;
      end
    end
  end

  assign mem_req_o.addr = {ent.wtag, off};
  assign mem_req_o.size = size;
  assign mem_req_o.data = req_data;
  assign mem_req_o.id   = issue_id_o;
  assign mem_valid_o    = any_cand && any_slot;
  assign issue_o        = mem_valid_o && mem_ack_i;
  assign issue_ptr_o    = sel;

endmodule

`default_nettype wire

// ==== hdl/wbuf_store.sv ====
// entry storage; the issue and eviction ports must never name the same entry in one cycle
`timescale 1ns/10ps
`default_nettype none

module wbuf_store #(
  parameter int depth = 4
) (
  input  wire logic                                       clk_i,
  input  wire logic                                       rst_ni,
  // core write port
  input  wire logic                                       wr_valid_i,
  input  wire wbuf_pkg::wr_req_t                          wr_req_i,
  output logic                                            wr_gnt_o,
  // bytes handed to memory this cycle
  input  wire logic                                       issue_i,
  input  wire logic [wbuf_pkg::ptr_width-1:0]             issue_ptr_i,
  input  wire logic [wbuf_pkg::data_bytes-1:0]            issue_be_i,
  // bytes whose transfer came back
  input  wire logic                                       evict_i,
  input  wire logic [wbuf_pkg::ptr_width-1:0]             evict_ptr_i,
  input  wire logic [wbuf_pkg::data_bytes-1:0]            evict_be_i,
  // buffer contents
  output wbuf_pkg::wbuf_entry_t [depth-1:0]               entries_o,
  output logic                                            empty_o
);

  // per-byte state
  logic [depth-1:0][wbuf_pkg::data_bytes-1:0] vld_q, vld_d;
  logic [depth-1:0][wbuf_pkg::data_bytes-1:0] dirty_q, dirty_d;
  logic [depth-1:0][wbuf_pkg::data_bytes-1:0] tx_q, tx_d;
  // word address and data
  logic [depth-1:0][wbuf_pkg::wtag_width-1:0] wtag_q, wtag_d;
  logic [depth-1:0][wbuf_pkg::data_width-1:0] data_q, data_d;

  logic [wbuf_pkg::wtag_width-1:0] req_tag;
  logic [depth-1:0]                word_vld;
  logic [depth-1:0]                hit_oh;
  logic [wbuf_pkg::ptr_width-1:0]  hit_ptr, free_ptr, wr_ptr;
  logic                            any_free;
  logic                            wr_take;

  ////////////////////////////////////////
  // hit and free-entry search
  ////////////////////////////////////////

  assign req_tag = wr_req_i.addr[wbuf_pkg::addr_width-1:wbuf_pkg::offset_width];

  for (genvar k = 0; k < depth; k++) begin : gen_hit
    // an entry is taken as long as any byte is valid
    assign word_vld[k] = |vld_q[k];
    assign hit_oh[k]   = word_vld[k] && (wtag_q[k] == req_tag);
    assign entries_o[k] = '{valid:   vld_q[k],
                            dirty:   dirty_q[k],
                            txblock: tx_q[k],
                            wtag:    wtag_q[k],
                            data:    data_q[k]};
  end

  // downward scan so the lowest index wins
  always_comb begin
    hit_ptr  = '0;
    free_ptr = '0;
    any_free = 1'b0;
    for (int k = depth - 1; k >= 0; k--) begin
      if (hit_oh[k]) begin
        hit_ptr = wbuf_pkg::ptr_width'(k);
      end
      if (!word_vld[k]) begin
        free_ptr = wbuf_pkg::ptr_width'(k);
        any_free = 1'b1;
      end
    end
  end

  // merge into the hit entry, else open the lowest free one
  assign wr_ptr   = (|hit_oh) ? hit_ptr : free_ptr;
  assign wr_gnt_o = (|hit_oh) || any_free;
  assign wr_take  = wr_valid_i && wr_gnt_o;
  assign empty_o  = ~|vld_q;

  ////////////////////////////////////////
  // byte state update
  ////////////////////////////////////////

  always_comb begin
    vld_d   = vld_q;
    dirty_d = dirty_q;
    tx_d    = tx_q;
    wtag_d  = wtag_q;
    data_d  = data_q;

    // a response unblocks its bytes and drops those not rewritten meanwhile
    if (evict_i) begin
      for (int j = 0; j < wbuf_pkg::data_bytes; j++) begin
        if (evict_be_i[j]) begin
          tx_d[evict_ptr_i][j] = 1'b0;
          if (!dirty_q[evict_ptr_i][j]) begin
            vld_d[evict_ptr_i][j] = 1'b0;
          end
        end
      end
    end

    // an accepted transfer moves its bytes from dirty to in flight
    if (issue_i) begin
      for (int j = 0; j < wbuf_pkg::data_bytes; j++) begin
        if (issue_be_i[j]) begin
          dirty_d[issue_ptr_i][j] = 1'b0;
          tx_d[issue_ptr_i][j]    = 1'b1;
        end
      end
    end

    // core write last, so a byte rewritten while in flight ends up 111
    if (wr_take) begin
      wtag_d[wr_ptr] = req_tag;
      for (int j = 0; j < wbuf_pkg::data_bytes; j++) begin
        if (wr_req_i.be[j]) begin
          vld_d[wr_ptr][j]            = 1'b1;
          dirty_d[wr_ptr][j]          = 1'b1;
          data_d[wr_ptr][j*8 +: 8]    = wr_req_i.data[j*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q   <= '0;
      dirty_q <= '0;
      tx_q    <= '0;
    end else begin
      vld_q   <= vld_d;
      dirty_q <= dirty_d;
      tx_q    <= tx_d;
    end
  end

  always_ff @(posedge clk_i) begin
    wtag_q <= wtag_d;
    data_q <= data_d;
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // tags stay unique across all writes, so a lookup never hits twice
  a_hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) wr_valid_i |-> $onehot0(hit_oh))
    else $error("write buffer: write address matches more than one entry");

  for (genvar k = 0; k < depth; k++) begin : gen_chk_entry
    for (genvar j = 0; j < wbuf_pkg::data_bytes; j++) begin : gen_chk_byte
      a_byte_state: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        {vld_q[k][j], dirty_q[k][j], tx_q[k][j]} inside {3'b000, 3'b110, 3'b101, 3'b111})
        else $error("write buffer: entry %0d byte %0d in illegal state", k, j);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/wbuf_pkg.sv ====
// widths and types for a 32-bit write buffer; ID fields fit max_tx <= 8, index fields depth <= 16
`default_nettype none

package wbuf_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // physical byte address
  localparam int addr_width   = 32;
  // bytes per word and byte offset bits
  localparam int data_bytes   = 4;
  localparam int offset_width = 2;
  localparam int data_width   = data_bytes * 8;
  // word address is the byte address without the offset
  localparam int wtag_width   = addr_width - offset_width;
  // fixed maximum widths for transaction IDs and entry indices
  localparam int id_width     = 3;
  localparam int ptr_width    = 4;

  ////////////////////////////////////////
  // memory transfer size codes
  ////////////////////////////////////////

  localparam logic [1:0] size_byte = 2'd0;
  localparam logic [1:0] size_half = 2'd1;
  localparam logic [1:0] size_word = 2'd2;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  // core write request
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
    logic [data_bytes-1:0] be;
  } wr_req_t;

  // one buffered word with three state bits per byte
  typedef struct packed {
    logic [data_bytes-1:0] valid;
    logic [data_bytes-1:0] dirty;
    logic [data_bytes-1:0] txblock;
    logic [wtag_width-1:0] wtag;
    logic [data_width-1:0] data;
  } wbuf_entry_t;

  // one aligned write to memory with the data replicated over the word
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [1:0]            size;
    logic [data_width-1:0] data;
    logic [id_width-1:0]   id;
  } mem_req_t;

  // outstanding transaction slot
  typedef struct packed {
    logic                  vld;
    logic [ptr_width-1:0]  ptr;
    logic [data_bytes-1:0] be;
  } tx_slot_t;

endpackage

`default_nettype wire
